// File: compile.f
+incdir+bench
common/spi_pkg.sv
common/regmap_pkg.sv
spi_port/spi_slave.sv
spi_port/spi_frame_ctrl.sv
hdl/reg_arbiter.sv
hdl/reg_bank.sv
hdl/spi_regs_top.sv
bench/tb_spi_regs.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator.
# Extra arguments go to verilator, e.g. ./run.sh -GCPOL=0 -GCPHA=0
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f compile.f --top-module tb_spi_regs -Mdir obj_dir "$@"
out=$(./obj_dir/Vtb_spi_regs 2>&1 || true)
printf '%s\n' "$out"
grep -qx "RESULT: PASS" <<< "$out"

// File: bench/spi_master_tasks.svh
/*
 * SPI master and LFSR helpers, included inside the testbench module.
 * Uses the module's CPOL, CPHA, HALF and pin signals. Bytes go MSB first.
 */
`ifndef SPI_MASTER_TASKS_SVH
`define SPI_MASTER_TASKS_SVH

logic [31:0] lfsr_state = 32'h868f6fe0;	// fibonacci, taps 32 22 2 1

// one lfsr step, returns the new bit
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

function automatic logic [7:0] rand_byte();
	logic [7:0] b;
	b = 8'h00;
	for (int i = 0; i < 8; i++)
		b = {b[6:0], lfsr_bit()};	// one step per bit
	return b;
endfunction

task automatic wait_cycles(input int n);
	repeat (n) @(posedge sys_clk);
endtask

// one frame on the enabled ports, both share the same sclk edges
task automatic spi_frame(input bit en_a, input bit en_b, input logic [15:0] mo_a,
		input logic [15:0] mo_b, input int nbits, output logic [15:0] mi_a,
		output logic [15:0] mi_b);
	mi_a = 16'h0000;
	mi_b = 16'h0000;
	@(posedge sys_clk);
	cs_a <= !en_a;
	cs_b <= !en_b;
	mosi_a <= en_a & mo_a[15];	// first bit ready for cpha 0
	mosi_b <= en_b & mo_b[15];
	wait_cycles(HALF - 1);
	for (int i = 0; i < nbits; i++) begin
		@(posedge sys_clk);	// leading edge
		if (CPHA) begin
			mosi_a <= en_a & mo_a[15 - i];
			mosi_b <= en_b & mo_b[15 - i];
		end else begin
			mi_a[15 - i] = miso_a;	// stable since the last trailing edge
			mi_b[15 - i] = miso_b;
		end
		sclk_a <= en_a ? !CPOL : CPOL;
		sclk_b <= en_b ? !CPOL : CPOL;
		wait_cycles(HALF - 1);
		@(posedge sys_clk);	// trailing edge
		if (CPHA) begin
			mi_a[15 - i] = miso_a;
			mi_b[15 - i] = miso_b;
		end else if (i < nbits - 1) begin
			mosi_a <= en_a & mo_a[14 - i];
			mosi_b <= en_b & mo_b[14 - i];
		end
		sclk_a <= CPOL;
		sclk_b <= CPOL;
		wait_cycles(HALF - 1);
	end
	@(posedge sys_clk);
	cs_a <= 1'b1;
	cs_b <= 1'b1;
	mosi_a <= 1'b0;
	mosi_b <= 1'b0;
	wait_cycles(HALF);	// gap between frames
endtask

`endif

// File: bench/tb_spi_regs.sv
/*
 * Testbench for the dual-port SPI register target, CPOL/CPHA by -G.
 * Table rows run in order against a byte model of the bank.
 * Each sclk half period lasts 10 sys_clk.
 */
`timescale 1ns/1ps

module tb_spi_regs import spi_pkg::*, regmap_pkg::*; #(
	parameter bit CPOL = 1'b1,
	parameter bit CPHA = 1'b1
);

	localparam int HALF = 10;	// sys_clk per sclk half period
	localparam int RST_CYC = 16;
	localparam int CLK_NS = 100;

	typedef enum int {OP_NONE, OP_RD, OP_WR, OP_WR_RND} op_e;	// per port action

	typedef struct {
		string name;
		int nbits;	// 8 cuts the frame after the command
		op_e op_a;
		logic [6:0] addr_a;
		logic [7:0] data_a;
		op_e op_b;
		logic [6:0] addr_b;
		logic [7:0] data_b;
	} row_t;

	logic sys_clk;
	logic sys_rst_n;
	logic cs_a;
	logic sclk_a;
	logic mosi_a;
	logic miso_a;
	logic cs_b;
	logic sclk_b;
	logic mosi_b;
	logic miso_b;
	logic [7:0] mdl [REG_DEPTH];	// expected bank contents
	row_t rows [$];
	bit rows_ready = 1'b0;

	spi_regs_top #(.CPOL(CPOL), .CPHA(CPHA)) dut (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.cs_a(cs_a), .sclk_a(sclk_a), .mosi_a(mosi_a), .miso_a(miso_a),
		.cs_b(cs_b), .sclk_b(sclk_b), .mosi_b(mosi_b), .miso_b(miso_b)
	);

	`include "spi_master_tasks.svh"

	task automatic check_byte(input string name, input logic [7:0] exp_v,
			input logic [7:0] act_v);
		if (act_v !== exp_v) begin
			$display("MISMATCH %s expected %02h actual %02h", name, exp_v, act_v);
			$display("RESULT: FAIL");
			$fatal(1, "byte check failed");
		end
	endtask

	task automatic add_row(input string name, input int nbits, input op_e op_a,
			input logic [6:0] addr_a, input logic [7:0] data_a, input op_e op_b,
			input logic [6:0] addr_b, input logic [7:0] data_b);
		row_t r;
		r.name = name;
		r.nbits = nbits;
		r.op_a = op_a;
		r.addr_a = addr_a;
		r.data_a = data_a;
		r.op_b = op_b;
		r.addr_b = addr_b;
		r.data_b = data_b;
		rows.push_back(r);
	endtask

	// mosi word plus the byte a read must return
	task automatic prep_port(input op_e op, input logic [6:0] addr, input logic [7:0] data,
			output logic [15:0] mo, output logic [7:0] exp_rd);
		bit we;
		logic [7:0] wd;
		we = (op == OP_WR) || (op == OP_WR_RND);
		if (op == OP_WR_RND)
			wd = rand_byte();	// lfsr only steps for random data
		else
			wd = data;
		mo = {we, addr, wd};
		exp_rd = we ? IDLE_TX : mdl[addr];	// write data byte returns idle
	endtask

	task automatic close_port(input string name, input logic [15:0] mo,
			input logic [15:0] mi, input logic [7:0] exp_rd, input int nbits);
		check_byte({name, " cmd"}, IDLE_TX, mi[15:8]);
		if (nbits == 16) begin
			check_byte({name, " data"}, exp_rd, mi[7:0]);
			if (mo[15] && mo[14:8] != ID_ADDR)
				mdl[mo[14:8]] = mo[7:0];	// id location is read-only
		end
	endtask

	task automatic build_table();
		// name, bits, port a op/addr/data, port b op/addr/data
		add_row("id_rd_a", 16, OP_RD, ID_ADDR, 8'h00, OP_NONE, 7'h00, 8'h00);
		add_row("id_rd_b", 16, OP_NONE, 7'h00, 8'h00, OP_RD, ID_ADDR, 8'h00);
		add_row("zero_rd_a", 16, OP_RD, 7'h10, 8'h00, OP_NONE, 7'h00, 8'h00);
		add_row("zero_rd_b", 16, OP_NONE, 7'h00, 8'h00, OP_RD, 7'h55, 8'h00);
		add_row("wr_rand_a", 16, OP_WR_RND, 7'h21, 8'h00, OP_NONE, 7'h00, 8'h00);
		add_row("rd_back_a", 16, OP_RD, 7'h21, 8'h00, OP_NONE, 7'h00, 8'h00);
		add_row("wr_rand_b", 16, OP_NONE, 7'h00, 8'h00, OP_WR_RND, 7'h33, 8'h00);
		add_row("rd_back_b", 16, OP_NONE, 7'h00, 8'h00, OP_RD, 7'h33, 8'h00);
		add_row("wr_fixed_a", 16, OP_WR, 7'h40, 8'h3C, OP_NONE, 7'h00, 8'h00);
		add_row("cross_rd_b", 16, OP_NONE, 7'h00, 8'h00, OP_RD, 7'h40, 8'h00);
		add_row("wr_cross_b", 16, OP_NONE, 7'h00, 8'h00, OP_WR_RND, 7'h41, 8'h00);
		add_row("cross_rd_a", 16, OP_RD, 7'h41, 8'h00, OP_NONE, 7'h00, 8'h00);
		add_row("both_wr_rd", 16, OP_WR_RND, 7'h50, 8'h00, OP_RD, 7'h21, 8'h00);
		add_row("both_wr_wr", 16, OP_WR_RND, 7'h51, 8'h00, OP_WR_RND, 7'h52, 8'h00);
		add_row("both_rd_rd", 16, OP_RD, 7'h52, 8'h00, OP_RD, 7'h51, 8'h00);
		add_row("after_rd_b", 16, OP_NONE, 7'h00, 8'h00, OP_RD, 7'h50, 8'h00);
		add_row("id_wr_a", 16, OP_WR, ID_ADDR, 8'h5A, OP_NONE, 7'h00, 8'h00);
		add_row("id_keep_b", 16, OP_NONE, 7'h00, 8'h00, OP_RD, ID_ADDR, 8'h00);
		add_row("cut_wr_a", 8, OP_WR, 7'h21, 8'hFF, OP_NONE, 7'h00, 8'h00);
		add_row("cut_rd_a", 16, OP_RD, 7'h21, 8'h00, OP_NONE, 7'h00, 8'h00);
	endtask

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;	// 100 ns period
	end

	// watchdog sized from the table length
	initial begin
		int wd_ns;
		wait (rows_ready);
		wd_ns = 2 * rows.size() * 2 * 16 * HALF * CLK_NS + RST_CYC * CLK_NS;
		#(wd_ns);
		$display("timeout: the frames did not complete within the watchdog limit");
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [15:0] mo_a;
		logic [15:0] mo_b;
		logic [15:0] mi_a;
		logic [15:0] mi_b;
		logic [7:0] ex_a;
		logic [7:0] ex_b;
		sys_rst_n = 1'b0;
		cs_a = 1'b1;
		cs_b = 1'b1;
		sclk_a = CPOL;	// idle level
		sclk_b = CPOL;
		mosi_a = 1'b0;
		mosi_b = 1'b0;
		for (int i = 0; i < REG_DEPTH; i++)
			mdl[i] = 8'h00;
		mdl[ID_ADDR] = ID_VALUE;
		build_table();
		rows_ready = 1'b1;
		wait_cycles(RST_CYC);
		sys_rst_n <= 1'b1;
		wait_cycles(HALF);
		foreach (rows[r]) begin
			prep_port(rows[r].op_a, rows[r].addr_a, rows[r].data_a, mo_a, ex_a);
			prep_port(rows[r].op_b, rows[r].addr_b, rows[r].data_b, mo_b, ex_b);
			spi_frame(rows[r].op_a != OP_NONE, rows[r].op_b != OP_NONE, mo_a, mo_b,
				rows[r].nbits, mi_a, mi_b);
			if (rows[r].op_a != OP_NONE)
				close_port({rows[r].name, " a"}, mo_a, mi_a, ex_a, rows[r].nbits);
			if (rows[r].op_b != OP_NONE)
				close_port({rows[r].name, " b"}, mo_b, mi_b, ex_b, rows[r].nbits);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: hdl/spi_regs_top.sv
/*
 * Dual-port SPI register target. Ports a and b share one register bank.
 * Both ports use the same CPOL/CPHA. Each sclk half period must last
 * at least 8 sys_clk so a read completes before its data byte is shifted.
 */
`timescale 1ns/1ps

module spi_regs_top import spi_pkg::*; #(
	parameter bit CPOL = 1'b1,
	parameter bit CPHA = 1'b1
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic cs_a,
	input  logic sclk_a,
	input  logic mosi_a,
	output logic miso_a,
	input  logic cs_b,
	input  logic sclk_b,
	input  logic mosi_b,
	output logic miso_b
);

	// port a
	logic [BYTE_W-1:0] rx_byte_a, tx_byte_a, req_wdata_a, rd_data_a;
	logic rx_valid_a, frame_start_a, frame_end_a;
	logic req_a, req_we_a, rd_valid_a;
	logic [CMD_ADDR_W-1:0] req_addr_a;

	// port b
	logic [BYTE_W-1:0] rx_byte_b, tx_byte_b, req_wdata_b, rd_data_b;
	logic rx_valid_b, frame_start_b, frame_end_b;
	logic req_b, req_we_b, rd_valid_b;
	logic [CMD_ADDR_W-1:0] req_addr_b;

	// bank side
	logic mem_en, mem_we;
	logic [CMD_ADDR_W-1:0] mem_addr;
	logic [BYTE_W-1:0] mem_wdata, mem_rdata;

	spi_slave #(.CPOL(CPOL), .CPHA(CPHA)) u_slave_a (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.cs(cs_a), .sclk(sclk_a), .mosi(mosi_a), .miso(miso_a),
		.tx_byte(tx_byte_a), .rx_byte(rx_byte_a), .rx_valid(rx_valid_a),
		.frame_start(frame_start_a), .frame_end(frame_end_a)
	);

	spi_frame_ctrl u_frame_a (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.rx_byte(rx_byte_a), .rx_valid(rx_valid_a),
		.frame_start(frame_start_a), .frame_end(frame_end_a),
		.rd_valid(rd_valid_a), .rd_data(rd_data_a), .tx_byte(tx_byte_a),
		.req(req_a), .req_we(req_we_a), .req_addr(req_addr_a), .req_wdata(req_wdata_a)
	);

	spi_slave #(.CPOL(CPOL), .CPHA(CPHA)) u_slave_b (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.cs(cs_b), .sclk(sclk_b), .mosi(mosi_b), .miso(miso_b),
		.tx_byte(tx_byte_b), .rx_byte(rx_byte_b), .rx_valid(rx_valid_b),
		.frame_start(frame_start_b), .frame_end(frame_end_b)
	);

	spi_frame_ctrl u_frame_b (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.rx_byte(rx_byte_b), .rx_valid(rx_valid_b),
		.frame_start(frame_start_b), .frame_end(frame_end_b),
		.rd_valid(rd_valid_b), .rd_data(rd_data_b), .tx_byte(tx_byte_b),
		.req(req_b), .req_we(req_we_b), .req_addr(req_addr_b), .req_wdata(req_wdata_b)
	);

	reg_arbiter u_arbiter (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.req_a(req_a), .req_we_a(req_we_a), .req_addr_a(req_addr_a), .req_wdata_a(req_wdata_a),
		.req_b(req_b), .req_we_b(req_we_b), .req_addr_b(req_addr_b), .req_wdata_b(req_wdata_b),
		.mem_rdata(mem_rdata),
		.rd_valid_a(rd_valid_a), .rd_data_a(rd_data_a),
		.rd_valid_b(rd_valid_b), .rd_data_b(rd_data_b),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	reg_bank u_bank (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

endmodule

// File: hdl/reg_bank.sv
/*
 * Byte-wide register bank, cleared by reset, one access per cycle.
 * ID_ADDR reads as ID_VALUE and ignores writes. Read data is valid
 * one cycle after mem_en and holds until the next read.
 */
`timescale 1ns/1ps

module reg_bank import spi_pkg::*, regmap_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic                  mem_en,
	input  logic                  mem_we,
	input  logic [CMD_ADDR_W-1:0] mem_addr,
	input  logic [BYTE_W-1:0]     mem_wdata,
	output logic [BYTE_W-1:0]     mem_rdata
);

	logic [BYTE_W-1:0] regs [REG_DEPTH];
	logic id_hit;

	assign id_hit = (mem_addr == ID_ADDR);

	// storage, cleared on reset
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < REG_DEPTH; i++)
				regs[i] <= '0;
		end else if (mem_en && mem_we && !id_hit) begin
			regs[mem_addr] <= mem_wdata;	// id location is read-only
		end
	end

	// registered read port
	always_ff @(posedge sys_clk) begin
		if (mem_en && !mem_we)
			mem_rdata <= id_hit ? ID_VALUE : regs[mem_addr];
	end

endmodule

// File: hdl/reg_arbiter.sv
/*
 * Round-robin arbiter, two SPI ports onto one bank port.
 * Each port may have one access in flight. A request is latched, then served
 * in the next cycle or one later on a conflict. Read data follows one cycle on.
 */
`timescale 1ns/1ps

module reg_arbiter import spi_pkg::*, regmap_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic                  req_a,
	input  logic                  req_we_a,
	input  logic [CMD_ADDR_W-1:0] req_addr_a,
	input  logic [BYTE_W-1:0]     req_wdata_a,
	input  logic                  req_b,
	input  logic                  req_we_b,
	input  logic [CMD_ADDR_W-1:0] req_addr_b,
	input  logic [BYTE_W-1:0]     req_wdata_b,
	input  logic [BYTE_W-1:0]     mem_rdata,
	output logic                  rd_valid_a,
	output logic [BYTE_W-1:0]     rd_data_a,
	output logic                  rd_valid_b,
	output logic [BYTE_W-1:0]     rd_data_b,
	output logic                  mem_en,
	output logic                  mem_we,
	output logic [CMD_ADDR_W-1:0] mem_addr,
	output logic [BYTE_W-1:0]     mem_wdata
);

	logic [N_PORTS-1:0] req_v;
	logic [N_PORTS-1:0] pend;	// one slot per port
	logic [N_PORTS-1:0] grant;
	logic [N_PORTS-1:0] rd_pend;	// read owner, one cycle after service
	logic [N_PORTS-1:0] slot_we;
	logic [CMD_ADDR_W-1:0] slot_addr [N_PORTS];
	logic [BYTE_W-1:0] slot_wdata [N_PORTS];
	logic last_b;	// port b served last
	logic sel;	// index of served slot

	assign req_v = {req_b, req_a};

	// request slots
	always_ff @(posedge sys_clk) begin
		if (req_a) begin
			slot_we[0] <= req_we_a;
			slot_addr[0] <= req_addr_a;
			slot_wdata[0] <= req_wdata_a;
		end
		if (req_b) begin
			slot_we[1] <= req_we_b;
			slot_addr[1] <= req_addr_b;
			slot_wdata[1] <= req_wdata_b;
		end
	end

	// a wins unless b is waiting and a went last
	assign grant[0] = pend[0] & (~pend[1] | last_b);
	assign grant[1] = pend[1] & ~grant[0];
	assign sel = grant[1];

	assign mem_en = |grant;
	assign mem_we = slot_we[sel];
	assign mem_addr = slot_addr[sel];
	assign mem_wdata = slot_wdata[sel];

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			pend <= '0;
			rd_pend <= '0;
			last_b <= 1'b0;
		end else begin
			pend <= (pend & ~grant) | req_v;
			rd_pend <= grant & {N_PORTS{~mem_we}};	// bank data lands next cycle
			if (mem_en)
				last_b <= sel;
		end
	end

	// bank read data is shared, the valid strobe picks the owner
	assign rd_valid_a = rd_pend[0];
	assign rd_data_a = mem_rdata;
	assign rd_valid_b = rd_pend[1];
	assign rd_data_b = mem_rdata;

endmodule

// File: spi_port/spi_frame_ctrl.sv
/*
 * Frame decoder for one port: command byte then one data byte.
 * Reads are requested right after the command, writes after the data byte.
 * A frame cut before the data byte makes no write. Extra bytes are ignored.
 */
`timescale 1ns/1ps

module spi_frame_ctrl import spi_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic [BYTE_W-1:0]     rx_byte,
	input  logic                  rx_valid,
	input  logic                  frame_start,
	input  logic                  frame_end,
	input  logic                  rd_valid,	// read return from arbiter
	input  logic [BYTE_W-1:0]     rd_data,
	output logic [BYTE_W-1:0]     tx_byte,	// held level to shifter
	output logic                  req,	// one cycle strobe
	output logic                  req_we,
	output logic [CMD_ADDR_W-1:0] req_addr,
	output logic [BYTE_W-1:0]     req_wdata
);

	localparam int IDX_W = $clog2(FRAME_BYTES + 1);
	localparam logic [IDX_W-1:0] CMD_IDX = '0;
	localparam logic [IDX_W-1:0] DATA_IDX = IDX_W'(FRAME_BYTES - 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_BYTES);	// past the data byte

	logic [IDX_W-1:0] byte_idx;	// saturates at LAST_IDX
	logic cmd_we;
	logic [CMD_ADDR_W-1:0] cmd_addr;
	logic cmd_seen;
	logic data_seen;

	assign cmd_seen = rx_valid && (byte_idx == CMD_IDX);
	assign data_seen = rx_valid && (byte_idx == DATA_IDX);

	// byte position inside the frame
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			byte_idx <= CMD_IDX;
		else if (frame_start || frame_end)
			byte_idx <= CMD_IDX;	// also drops a cut frame
		else if (rx_valid && byte_idx != LAST_IDX)
			byte_idx <= byte_idx + 1'b1;
	end

	// command decode and request strobe
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cmd_we <= 1'b0;
			cmd_addr <= '0;
			req <= 1'b0;
		end else begin
			if (cmd_seen) begin
				cmd_we <= rx_byte[CMD_WR_BIT];
				cmd_addr <= rx_byte[CMD_ADDR_W-1:0];
			end
			// read goes out at once, write waits for its data
			req <= (cmd_seen && !rx_byte[CMD_WR_BIT]) || (data_seen && cmd_we);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (data_seen)
			req_wdata <= rx_byte;	// valid with the write strobe
	end

	assign req_we = cmd_we;
	assign req_addr = cmd_addr;

	// miso source
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			tx_byte <= IDLE_TX;
		else if (frame_start || frame_end)
			tx_byte <= IDLE_TX;
		else if (rd_valid && byte_idx != CMD_IDX)
			tx_byte <= rd_data;	// held until cs rises
	end

endmodule

// File: spi_port/spi_slave.sv
/*
 * SPI slave byte shifter with the mode set by CPOL/CPHA.
 * Pins are resampled on sys_clk, so each sclk half period needs 8+ sys_clk.
 * Strobes lag the pin edge by 3 cycles. cs must fall with sclk at CPOL.
 */
`timescale 1ns/1ps

module spi_slave import spi_pkg::*; #(
	parameter bit CPOL = 1'b1,	// sclk idle level
	parameter bit CPHA = 1'b1	// 1: drive on leading, sample on trailing
) (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic              cs,	// active low
	input  logic              sclk,
	input  logic              mosi,
	output logic              miso,
	input  logic [BYTE_W-1:0] tx_byte,	// level from frame decoder
	output logic [BYTE_W-1:0] rx_byte,
	output logic              rx_valid,	// one cycle per received byte
	output logic              frame_start,	// cs fell
	output logic              frame_end	// cs rose
);

	localparam int CNT_W = $clog2(BYTE_W);

	logic [2:0] cs_sr;	// [0] meta, [1] sync, [2] previous
	logic [2:0] sclk_sr;
	logic [1:0] mosi_sr;	// aligned with sclk_sr[1]
	logic cs_active;
	logic cs_fall;
	logic cs_rise;
	logic sclk_lead;
	logic sclk_trail;
	logic sample_edge;
	logic drive_edge;
	logic tx_load;
	logic [CNT_W-1:0] bit_cnt;
	logic [BYTE_W-2:0] rx_shift;	// first seven bits of the byte
	logic [BYTE_W-1:0] tx_shift;

	// pin synchronizers
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_sr <= 3'b111;	// deselected
			sclk_sr <= {3{CPOL}};	// idle level
		end else begin
			cs_sr <= {cs_sr[1:0], cs};
			sclk_sr <= {sclk_sr[1:0], sclk};
		end
	end

	always_ff @(posedge sys_clk) begin
		mosi_sr <= {mosi_sr[0], mosi};	// same depth as sclk path
	end

	assign cs_active = ~cs_sr[1];
	assign cs_fall = cs_sr[2] & ~cs_sr[1];
	assign cs_rise = ~cs_sr[2] & cs_sr[1];

	// leading edge leaves the idle level, trailing edge returns to it
	assign sclk_lead = cs_active && (sclk_sr[2] == CPOL) && (sclk_sr[1] != CPOL);
	assign sclk_trail = cs_active && (sclk_sr[2] != CPOL) && (sclk_sr[1] == CPOL);
	assign sample_edge = CPHA ? sclk_trail : sclk_lead;
	assign drive_edge = CPHA ? sclk_lead : sclk_trail;

	// new byte enters the tx shifter at a byte boundary
	// cpha 0 needs bit 7 on the pin before the first edge, so also at cs fall
	assign tx_load = (!CPHA && cs_fall) || (drive_edge && bit_cnt == '0);

	// bit count and strobes
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			bit_cnt <= '0;
			rx_valid <= 1'b0;
			frame_start <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			frame_start <= cs_fall;
			frame_end <= cs_rise;
			rx_valid <= sample_edge && (bit_cnt == CNT_W'(BYTE_W - 1));	// eighth sample
			if (!cs_active)
				bit_cnt <= '0;	// cut frames restart cleanly
			else if (sample_edge)
				bit_cnt <= bit_cnt + 1'b1;	// wraps to 0 after bit 7
		end
	end

	// msb first receive shifter
	always_ff @(posedge sys_clk) begin
		if (sample_edge) begin
			rx_shift <= {rx_shift[BYTE_W-3:0], mosi_sr[1]};
			if (bit_cnt == CNT_W'(BYTE_W - 1))
				rx_byte <= {rx_shift, mosi_sr[1]};
		end
	end

	// msb first transmit shifter
	always_ff @(posedge sys_clk) begin
		if (tx_load)
			tx_shift <= {tx_byte[BYTE_W-2:0], 1'b0};	// bit 7 goes straight to miso
		else if (drive_edge)
			tx_shift <= {tx_shift[BYTE_W-2:0], 1'b0};
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			miso <= 1'b0;
		else if (cs_rise)
			miso <= 1'b0;	// park low between frames
		else if (tx_load)
			miso <= tx_byte[BYTE_W-1];
		else if (drive_edge)
			miso <= tx_shift[BYTE_W-1];
	end

endmodule

// File: common/regmap_pkg.sv
/*
 * Register bank geometry and the fixed ID location.
 * ID_ADDR must lie inside REG_DEPTH. Writes to it are dropped.
 */
package regmap_pkg;

	// bank size, one byte per entry
	localparam int unsigned REG_DEPTH = 128;	// full 7 bit address space

	// read-only identification byte
	localparam logic [6:0] ID_ADDR = 7'h7F;	// top of the map
	localparam logic [7:0] ID_VALUE = 8'hA5;

	// peer spi ports sharing the bank through the arbiter
	localparam int unsigned N_PORTS = 2;

endpackage

// File: common/spi_pkg.sv
/*
 * SPI framing constants shared by the slave shifter and the frame decoder.
 * One frame is a command byte then a data byte, MSB first.
 */
package spi_pkg;

	// byte shifter
	localparam int unsigned BYTE_W = 8;	// bits per spi byte

	// command byte layout
	localparam int unsigned CMD_WR_BIT = 7;	// 1 = write, 0 = read
	localparam int unsigned CMD_ADDR_W = 7;	// register address in bits 6:0

	// frame layout
	localparam int unsigned FRAME_BYTES = 2;	// command + data, no burst

	// miso filler when no read data is due
	// covers the command byte and the data byte of a write
	localparam logic [BYTE_W-1:0] IDLE_TX = 8'h00;

endpackage
